// File: list.f
+incdir+source
source/blit_pkg.sv
source/blit_reg_decode.sv
source/blit_sequencer.sv
source/blit_nibble_merge.sv
source/blitter_top.sv
bench/blit_mem_model.sv
bench/blitter_tb.sv

// File: run.sh
#!/bin/sh
# Build the blitter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary -f list.f --top-module blitter_tb -o blitter_sim &&
./obj_dir/blitter_sim | tee /dev/stderr | grep -q "test passed" ||
{ echo "blitter simulation did not pass"; exit 1; }

// File: bench/blitter_tb.sv
/*
 * Sprite blitter testbench
 * Directed jobs against a reference copy of the video RAM, with busy
 * timing, transparency, odd halves and ignored restarts checked
 */
`timescale 1ns/1ps
`include "blit_macros.svh"

module blitter_tb;

	localparam int MEM_SIZE = 1 << `BLIT_VRAM_AW;
	localparam int JOB_CYCLES = 1024;
	// Reset, preload, six tests of up to 1200 cycles and some slack
	localparam int WATCHDOG_NS = (10 + MEM_SIZE + 6 * 1200 + 100) * 20;

	logic                     clk_49m;
	logic                     reset;
	blit_pkg::cpu_wr_t        cpu_wr;
	logic [`BLIT_ROM_AW-1:0]  rom_addr;
	logic [7:0]               rom_data;
	blit_pkg::vram_req_t      vram_req;
	logic [7:0]               vram_rdata;
	logic                     busy_o;
	logic                     load_we;
	logic [`BLIT_VRAM_AW-1:0] load_addr;
	logic [7:0]               load_rom;
	logic [7:0]               load_vram;

	logic [7:0]  ref_rom  [MEM_SIZE];
	logic [7:0]  ref_vram [MEM_SIZE];
	logic [31:0] lcg_state;
	int          errors;
	int          checks;

	blitter_top blitter_top_i (
		.clk_49m      (clk_49m),
		.reset        (reset),
		.cpu_wr_i     (cpu_wr),
		.rom_addr_o   (rom_addr),
		.rom_data_i   (rom_data),
		.vram_req_o   (vram_req),
		.vram_rdata_i (vram_rdata),
		.busy_o       (busy_o)
	);

	blit_mem_model blit_mem_model_i (
		.clk_49m      (clk_49m),
		.load_we_i    (load_we),
		.load_addr_i  (load_addr),
		.load_rom_i   (load_rom),
		.load_vram_i  (load_vram),
		.rom_addr_i   (rom_addr),
		.rom_data_o   (rom_data),
		.vram_req_i   (vram_req),
		.vram_rdata_o (vram_rdata)
	);

	initial begin
		clk_49m = 1'b0;
		forever #10 clk_49m = ~clk_49m;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests finished");
		$display("test failed");
		$finish;
	end

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Every task starts and ends 2 ns after a rising edge
	task automatic cpu_write(input blit_pkg::blit_reg_e offset, input logic [7:0] data);
		cpu_wr.stb    = 1'b1;
		cpu_wr.offset = offset;
		cpu_wr.data   = data;
		@(posedge clk_49m);
		#2;
		cpu_wr.stb = 1'b0;
	endtask

	// Random bytes for both memories, with roughly a quarter of the
	// sprite nibbles forced transparent
	task automatic load_memories();
		logic [31:0] r;
		logic [7:0]  rb;
		for (int a = 0; a < MEM_SIZE; a++) begin
			r  = lcg_next();
			rb = r[23:16];
			if (r[27:26] == 2'd0) rb[7:4] = 4'h0;
			if (r[29:28] == 2'd0) rb[3:0] = 4'h0;
			ref_rom[a] = rb;
			r = lcg_next();
			ref_vram[a] = r[23:16];
			load_we   = 1'b1;
			load_addr = 15'(a);
			load_rom  = rb;
			load_vram = r[23:16];
			@(posedge clk_49m);
			#2;
		end
		load_we = 1'b0;
	endtask

	// Rows sit 256 nibbles apart in the destination, the source is linear
	function automatic void apply_reference(input logic [15:0] dest, input logic [15:0] src,
	                                        input logic copy);
		logic [15:0] n;
		logic [15:0] s;
		logic [7:0]  vb;
		logic [3:0]  sn;
		for (int r = 0; r < `BLIT_DIM; r++) begin
			for (int c = 0; c < `BLIT_DIM; c++) begin
				n  = dest + 16'(r * 256 + c);
				s  = src + 16'(r * `BLIT_DIM + c);
				sn = s[0] ? ref_rom[s[15:1]][3:0] : ref_rom[s[15:1]][7:4];
				// Zero source nibbles leave the destination alone
				if (sn != 4'h0) begin
					vb = ref_vram[n[15:1]];
					if (n[0]) vb[7:4] = copy ? sn : 4'h0;
					else vb[3:0] = copy ? sn : 4'h0;
					ref_vram[n[15:1]] = vb;
				end
			end
		end
	endfunction

	task automatic compare_vram(input string name);
		for (int a = 0; a < MEM_SIZE; a++) begin
			checks++;
			if (blit_mem_model_i.vram[a] !== ref_vram[a]) begin
				errors++;
				$display("CHECK FAILED: %s vram[%h] got %h expected %h", name, 15'(a),
				         blit_mem_model_i.vram[a], ref_vram[a]);
			end
		end
	endtask

	// Loads the registers, then counts busy cycles until the job ends
	task automatic run_job(input string name, input logic [15:0] dest, input logic [7:0] src_hi,
	                       input logic [7:0] src_lo, input bit retrigger);
		int cycles;
		apply_reference(dest, {src_hi, src_lo} & ~16'h0003, src_lo[0]);
		cpu_write(blit_pkg::REG_DEST_HI, dest[15:8]);
		cpu_write(blit_pkg::REG_DEST_LO, dest[7:0]);
		cpu_write(blit_pkg::REG_SRC_HI, src_hi);
		cpu_write(blit_pkg::REG_SRC_LO, src_lo);
		cycles = 0;
		while (busy_o && cycles < 2000) begin
			// A restart with the copy flag flipped must be dropped
			if (retrigger && cycles == 100) begin
				cpu_wr.stb    = 1'b1;
				cpu_wr.offset = blit_pkg::REG_SRC_LO;
				cpu_wr.data   = ~src_lo;
			end
			@(posedge clk_49m);
			#2;
			cpu_wr.stb = 1'b0;
			cycles++;
		end
		if (cycles >= 2000) begin
			$display("%s: busy_o never fell after the start write", name);
		end
		checks++;
		if (cycles != JOB_CYCLES) begin
			errors++;
			$display("CHECK FAILED: %s busy_o high for %h cycles, expected %h", name, cycles,
			         JOB_CYCLES);
		end
		compare_vram(name);
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic idle_after_reset();
		for (int i = 0; i < 50; i++) begin
			checks++;
			if (busy_o !== 1'b0 || vram_req.we !== 1'b0) begin
				errors++;
				$display("CHECK FAILED: idle busy_o %h vram_req_o.we %h expected 0 0",
				         busy_o, vram_req.we);
			end
			@(posedge clk_49m);
			#2;
		end
	endtask

	task automatic copy_even_dest();
		run_job("copy_even_dest", 16'h1230, 8'h04, 8'h41, 1'b0);
	endtask

	// Same sprite over the same block, so every copied pixel is cleared
	task automatic erase_block();
		run_job("erase_block", 16'h1230, 8'h04, 8'h40, 1'b0);
	endtask

	task automatic copy_odd_dest();
		run_job("copy_odd_dest", 16'h4567, 8'h21, 8'h0f, 1'b0);
	endtask

	task automatic erase_odd_dest();
		run_job("erase_odd_dest", 16'h4567, 8'h3a, 8'h36, 1'b0);
	endtask

	// Destination near the top so the last rows wrap around
	task automatic retrigger_ignored();
		run_job("retrigger_ignored", 16'hfa0b, 8'h52, 8'h85, 1'b1);
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		lcg_state = 32'hfc4d;
		reset     = 1'b0;
		cpu_wr    = '0;
		load_we   = 1'b0;
		load_addr = '0;
		load_rom  = 8'h00;
		load_vram = 8'h00;
		repeat (10) @(posedge clk_49m);
		#2;
		reset = 1'b1;

		idle_after_reset();
		load_memories();
		copy_even_dest();
		erase_block();
		copy_odd_dest();
		erase_odd_dest();
		retrigger_ignored();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: bench/blit_mem_model.sv
/*
 * Blitter memory model
 * Sprite ROM and video RAM, each with a one-cycle registered read,
 * plus a load port that the testbench uses to preset both memories
 */
`timescale 1ns/1ps
`include "blit_macros.svh"

module blit_mem_model (
	input  logic                     clk_49m,
	input  logic                     load_we_i,
	input  logic [`BLIT_VRAM_AW-1:0] load_addr_i,
	input  logic [7:0]               load_rom_i,
	input  logic [7:0]               load_vram_i,
	input  logic [`BLIT_ROM_AW-1:0]  rom_addr_i,
	output logic [7:0]               rom_data_o,
	input  blit_pkg::vram_req_t      vram_req_i,
	output logic [7:0]               vram_rdata_o
);

	logic [7:0] rom  [1 << `BLIT_ROM_AW];
	logic [7:0] vram [1 << `BLIT_VRAM_AW];

	// Preload has priority, the DUT is idle while it runs
	always_ff @(posedge clk_49m) begin
		if (load_we_i) begin
			rom[load_addr_i]  <= load_rom_i;
			vram[load_addr_i] <= load_vram_i;
		end else if (vram_req_i.we) begin
			vram[vram_req_i.addr] <= vram_req_i.wdata;
		end
	end

	// Both reads answer one cycle after the address
	always_ff @(posedge clk_49m) begin
		rom_data_o   <= rom[rom_addr_i];
		vram_rdata_o <= vram[vram_req_i.addr];
	end

endmodule

// File: source/blitter_top.sv
/*
 * Sprite blitter top level
 * Connects the register decode, the nibble sequencer and the merge stage
 * to the CPU write port, the sprite ROM and the video RAM
 */
`timescale 1ns/1ps
`include "blit_macros.svh"

module blitter_top (
	input  logic                    clk_49m,
	input  logic                    reset,
	input  blit_pkg::cpu_wr_t       cpu_wr_i,
	output logic [`BLIT_ROM_AW-1:0] rom_addr_o,
	input  logic [7:0]              rom_data_i,
	output blit_pkg::vram_req_t     vram_req_o,
	input  logic [7:0]              vram_rdata_i,
	output logic                    busy_o
);

	// Decode to sequencer
	logic                     job_start;
	blit_pkg::blit_job_t      job;

	// Sequencer to merge
	logic [`BLIT_VRAM_AW-1:0] vram_addr;
	logic                     src_odd;
	logic                     dest_odd;
	logic                     copy;
	logic                     merge_stb;

	blit_reg_decode blit_reg_decode_i (
		.clk_49m     (clk_49m),
		.reset       (reset),
		.cpu_wr_i    (cpu_wr_i),
		.busy_i      (busy_o),
		.job_start_o (job_start),
		.job_o       (job)
	);

	blit_sequencer blit_sequencer_i (
		.clk_49m     (clk_49m),
		.reset       (reset),
		.job_start_i (job_start),
		.job_i       (job),
		.busy_o      (busy_o),
		.rom_addr_o  (rom_addr_o),
		.vram_addr_o (vram_addr),
		.src_odd_o   (src_odd),
		.dest_odd_o  (dest_odd),
		.copy_o      (copy),
		.merge_stb_o (merge_stb)
	);

	blit_nibble_merge blit_nibble_merge_i (
		.clk_49m      (clk_49m),
		.reset        (reset),
		.merge_stb_i  (merge_stb),
		.vram_addr_i  (vram_addr),
		.src_odd_i    (src_odd),
		.dest_odd_i   (dest_odd),
		.copy_i       (copy),
		.rom_data_i   (rom_data_i),
		.vram_rdata_i (vram_rdata_i),
		.vram_req_o   (vram_req_o)
	);

endmodule

// File: source/blit_nibble_merge.sv
/*
 * Blitter nibble merge
 * Builds the read-modify-write byte from the sprite ROM nibble and the
 * video RAM byte and drives the video RAM request
 */
`timescale 1ns/1ps
`include "blit_macros.svh"

module blit_nibble_merge (
	input  logic                     clk_49m,
	input  logic                     reset,
	input  logic                     merge_stb_i,
	input  logic [`BLIT_VRAM_AW-1:0] vram_addr_i,
	input  logic                     src_odd_i,
	input  logic                     dest_odd_i,
	input  logic                     copy_i,
	input  logic [7:0]               rom_data_i,
	input  logic [7:0]               vram_rdata_i,
	output blit_pkg::vram_req_t      vram_req_o
);

	logic [3:0] src_nib;
	logic [3:0] new_nib;
	logic [7:0] merged;
	logic       we_q;
	logic [7:0] wdata_q;

	// ========================================
	// Merge
	// ========================================

	// Odd source nibbles sit in the low half of the ROM byte
	assign src_nib = src_odd_i ? rom_data_i[3:0] : rom_data_i[7:4];

	// Erase writes zero where the sprite has a pixel
	assign new_nib = copy_i ? src_nib : 4'h0;

	// Odd destination nibbles sit in the high half of the video RAM byte
	assign merged = dest_odd_i ? {new_nib, vram_rdata_i[3:0]}
	                           : {vram_rdata_i[7:4], new_nib};

	// Zero source nibbles are transparent and produce no write
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			we_q <= 1'b0;
		end else begin
			we_q <= merge_stb_i && (src_nib != 4'h0);
		end
	end

	always_ff @(posedge clk_49m) begin
		if (merge_stb_i) begin
			wdata_q <= merged;
		end
	end

	// ========================================
	// Video RAM request
	// ========================================

	// The sequencer holds the byte address for the whole nibble,
	// so the write reuses the address the read went out on
	always_comb begin
		vram_req_o.addr  = vram_addr_i;
		vram_req_o.we    = we_q;
		vram_req_o.wdata = wdata_q;
	end

endmodule

// File: source/blit_sequencer.sv
/*
 * Blitter nibble sequencer
 * Walks a 16 by 16 nibble job in four phases per nibble and presents
 * the sprite ROM and video RAM byte addresses to the memories
 */
`timescale 1ns/1ps
`include "blit_macros.svh"

module blit_sequencer (
	input  logic                     clk_49m,
	input  logic                     reset,
	input  logic                     job_start_i,
	input  blit_pkg::blit_job_t      job_i,
	output logic                     busy_o,
	output logic [`BLIT_ROM_AW-1:0]  rom_addr_o,
	output logic [`BLIT_VRAM_AW-1:0] vram_addr_o,
	output logic                     src_odd_o,
	output logic                     dest_odd_o,
	output logic                     copy_o,
	output logic                     merge_stb_o
);

	localparam int CNT_W = $clog2(`BLIT_DIM);
	localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`BLIT_DIM - 1);

	blit_pkg::blit_phase_e phase;
	logic                  busy_q;
	logic [CNT_W-1:0]      row_q;
	logic [CNT_W-1:0]      col_q;

	// Running nibble addresses of the current job
	logic [15:0]           src_q;
	logic [15:0]           dest_q;
	logic                  copy_q;

	logic                  last_col;
	logic                  last_row;

	assign last_col = (col_q == LAST_IDX);
	assign last_row = (row_q == LAST_IDX);

	// ========================================
	// Phase machine and counters
	// ========================================

	// The decode only pulses job_start when idle
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			busy_q <= 1'b0;
			phase  <= blit_pkg::PH_FETCH;
			row_q  <= '0;
			col_q  <= '0;
		end else if (job_start_i) begin
			busy_q <= 1'b1;
			phase  <= blit_pkg::PH_FETCH;
			row_q  <= '0;
			col_q  <= '0;
		end else if (busy_q) begin
			case (phase)
				blit_pkg::PH_FETCH: begin
					phase <= blit_pkg::PH_WAIT;
				end
				blit_pkg::PH_WAIT: begin
					phase <= blit_pkg::PH_MERGE;
				end
				blit_pkg::PH_MERGE: begin
					phase <= blit_pkg::PH_ADVANCE;
				end
				blit_pkg::PH_ADVANCE: begin
					phase <= blit_pkg::PH_FETCH;
					if (last_col) begin
						col_q <= '0;
						// The final write goes out on this cycle, so busy can drop here
						if (last_row) begin
							busy_q <= 1'b0;
							row_q  <= '0;
						end else begin
							row_q <= row_q + 1'b1;
						end
					end else begin
						col_q <= col_q + 1'b1;
					end
				end
				default: begin
					phase <= blit_pkg::PH_FETCH;
				end
			endcase
		end
	end

	// ========================================
	// Address path
	// ========================================

	always_ff @(posedge clk_49m) begin
		if (job_start_i) begin
			src_q  <= job_i.src;
			dest_q <= job_i.dest;
			copy_q <= job_i.copy;
		end else if (busy_q) begin
			// Byte addresses and nibble selects stay put until the next fetch
			if (phase == blit_pkg::PH_FETCH) begin
				rom_addr_o  <= src_q[`BLIT_ROM_AW:1];
				vram_addr_o <= dest_q[`BLIT_VRAM_AW:1];
				src_odd_o   <= src_q[0];
				dest_odd_o  <= dest_q[0];
			end
			if (phase == blit_pkg::PH_ADVANCE) begin
				src_q <= src_q + 16'd1;
				// At the row end the destination jumps to the next screen row
				if (last_col) begin
					dest_q <= dest_q + `BLIT_ROW_SKIP;
				end else begin
					dest_q <= dest_q + 16'd1;
				end
			end
		end
	end

	assign busy_o      = busy_q;
	assign copy_o      = copy_q;
	// Both memories have answered by the merge phase
	assign merge_stb_o = busy_q && (phase == blit_pkg::PH_MERGE);

endmodule

// File: source/blit_reg_decode.sv
/*
 * Blitter register decode
 * Holds the four byte registers written by the CPU and issues a job
 * when the source low byte is written while the blitter is idle
 */
`timescale 1ns/1ps
`include "blit_macros.svh"

module blit_reg_decode (
	input  logic                clk_49m,
	input  logic                reset,
	input  blit_pkg::cpu_wr_t   cpu_wr_i,
	input  logic                busy_i,
	output logic                job_start_o,
	output blit_pkg::blit_job_t job_o
);

	// Register file indexed directly by the register offset
	logic [7:0] regs [`BLIT_REG_COUNT];

	// Write strobe aimed at the trigger register
	logic       src_lo_wr;

	assign src_lo_wr = cpu_wr_i.stb && (cpu_wr_i.offset == blit_pkg::REG_SRC_LO);

	// ========================================
	// Register writes
	// ========================================

	// Writes land at any time, a running job keeps its own copy
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			for (int i = 0; i < `BLIT_REG_COUNT; i++) begin
				regs[i] <= 8'h00;
			end
		end else if (cpu_wr_i.stb) begin
			regs[cpu_wr_i.offset] <= cpu_wr_i.data;
		end
	end

	// ========================================
	// Job issue
	// ========================================

	// A trigger write during a job is ignored apart from the register update
	assign job_start_o = src_lo_wr && !busy_i;

	// The low source byte is taken from the bus since the register is
	// only loaded on the same edge that starts the job
	always_comb begin
		job_o.src  = {regs[blit_pkg::REG_SRC_HI], cpu_wr_i.data} & `BLIT_SRC_MASK;
		job_o.dest = {regs[blit_pkg::REG_DEST_HI], regs[blit_pkg::REG_DEST_LO]};
		// Bit 0 set selects copy, clear selects erase
		job_o.copy = cpu_wr_i.data[0];
	end

endmodule

// File: source/blit_pkg.sv
/*
 * Sprite blitter types
 * Register and phase encodings, plus the bundles passed between the
 * CPU port, the register decode, the sequencer and the video RAM port
 */
`include "blit_macros.svh"

package blit_pkg;

	// ========================================
	// Encodings
	// ========================================

	// Register offsets as seen on the CPU write port
	typedef enum logic [1:0] {
		REG_DEST_HI = 2'd0,
		REG_DEST_LO = 2'd1,
		REG_SRC_HI  = 2'd2,
		REG_SRC_LO  = 2'd3
	} blit_reg_e;

	// Four phases per nibble, in the order they run
	typedef enum logic [1:0] {
		PH_FETCH   = 2'd0,
		PH_WAIT    = 2'd1,
		PH_MERGE   = 2'd2,
		PH_ADVANCE = 2'd3
	} blit_phase_e;

	// ========================================
	// Bundles
	// ========================================

	// One CPU write cycle to the blitter registers
	typedef struct packed {
		logic       stb;
		blit_reg_e  offset;
		logic [7:0] data;
	} cpu_wr_t;

	// Job as captured on the start write, both addresses count nibbles
	typedef struct packed {
		logic [15:0] src;
		logic [15:0] dest;
		logic        copy;
	} blit_job_t;

	// Video RAM port request, a read whenever we is low
	typedef struct packed {
		logic [`BLIT_VRAM_AW-1:0] addr;
		logic                     we;
		logic [7:0]               wdata;
	} vram_req_t;

endpackage

// File: source/blit_macros.svh
/*
 * Sprite blitter constants
 * Job geometry, address masks and memory address widths shared by the
 * register decode, the sequencer and the merge stage
 */
`ifndef BLIT_MACROS_SVH
`define BLIT_MACROS_SVH

// ========================================
// Job geometry
// ========================================

// A job walks this many rows and this many nibble columns per row
`define BLIT_DIM 16

// Destination step taken after a row's last column
// One step to the next nibble plus 240 to reach the next 256-nibble row
`define BLIT_ROW_SKIP 16'd241

// The two low source bits are dropped at job start
// Bit 0 of the written byte doubles as the copy flag
`define BLIT_SRC_MASK 16'hfffc

// Number of CPU visible blitter registers
`define BLIT_REG_COUNT 4

// ========================================
// Memory address widths
// ========================================

// Byte address into the 32 KB video RAM
`define BLIT_VRAM_AW 15

// Byte address into the sprite ROM
`define BLIT_ROM_AW 15

`endif
